// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_bank_if.sv
hdl/icache_bank.sv
hdl/fetch_unit.sv
hdl/fetch_frontend_top.sv
tests/fetch_frontend_tb.sv

// ==== hdl/fetch_bank_if.sv ====
`timescale 1ns/100ps

interface fetch_bank_if import fetch_pkg::*; ();

    // Read request and global line index
    logic      rreq;
    line_idx_t raddr;

    // Response one cycle after rreq
    logic      rvalid;
    line_t     rdata;

    modport fetch (
        output rreq,
        output raddr,
        input  rvalid,
        input  rdata
    );

    modport bank (
        input  rreq,
        input  raddr,
        output rvalid,
        output rdata
    );

endinterface

// ==== hdl/fetch_frontend_top.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_frontend_top import fetch_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    // Fetch target queue
    input  logic                      ftq_valid_i,
    input  addr_t                     ftq_pc_i,
    input  fetch_len_t                ftq_len_i,
    output logic                      ftq_accept_o,

    // Instruction memory load
    input  logic                      mem_we_i,
    input  line_idx_t                 mem_line_i,
    input  line_t                     mem_wdata_i,

    // Instruction buffer
    input  logic                      ib_stall_i,
    output logic [`FETCH_WIDTH-1:0]   ib_valid_o,
    output logic [`FETCH_WIDTH-1:0]   ib_last_o,
    output addr_t [`FETCH_WIDTH-1:0]  ib_pc_o,
    output instr_t [`FETCH_WIDTH-1:0] ib_instr_o,

    // Backend redirect
    input  logic                      flush_i
);

    fetch_bank_if bank0_if ();
    fetch_bank_if bank1_if ();

    // Even lines
    icache_bank #(
        .BANK_ID (0)
    ) u_bank0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_we_i    (mem_we_i),
        .mem_line_i  (mem_line_i),
        .mem_wdata_i (mem_wdata_i),
        .bank        (bank0_if.bank)
    );

    // Odd lines
    icache_bank #(
        .BANK_ID (1)
    ) u_bank1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_we_i    (mem_we_i),
        .mem_line_i  (mem_line_i),
        .mem_wdata_i (mem_wdata_i),
        .bank        (bank1_if.bank)
    );

    fetch_unit u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .ftq_valid_i  (ftq_valid_i),
        .ftq_pc_i     (ftq_pc_i),
        .ftq_len_i    (ftq_len_i),
        .ftq_accept_o (ftq_accept_o),
        .bank0        (bank0_if.fetch),
        .bank1        (bank1_if.fetch),
        .ib_stall_i   (ib_stall_i),
        .ib_valid_o   (ib_valid_o),
        .ib_last_o    (ib_last_o),
        .ib_pc_o      (ib_pc_o),
        .ib_instr_o   (ib_instr_o)
    );

endmodule

// ==== hdl/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Instruction lanes delivered per fetch block
`define FETCH_WIDTH 4

// PC and byte address width
`define ADDR_WIDTH 32

// One fixed-size instruction word
`define INSTR_WIDTH 32

// Bank line, four instruction words
`define LINE_WIDTH 128

// Lines per bank as a power of two
`define BANK_DEPTH_LOG2 6

`endif

// ==== hdl/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    // PC or byte address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Single instruction word
    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // Full cache line as returned by a bank
    typedef logic [`LINE_WIDTH-1:0] line_t;

    // Global line number, low bit selects the bank
    typedef logic [`BANK_DEPTH_LOG2:0] line_idx_t;

    // Block length, 1 to 4
    typedef logic [2:0] fetch_len_t;

    // Flush tracking
    typedef enum logic {
        FLUSH_IDLE,
        FLUSH_DRAIN
    } flush_state_e;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,

    // Fetch target queue
    input  logic                      ftq_valid_i,
    input  addr_t                     ftq_pc_i,
    input  fetch_len_t                ftq_len_i,
    output logic                      ftq_accept_o,

    // Even and odd line banks
    fetch_bank_if.fetch               bank0,
    fetch_bank_if.fetch               bank1,

    // Instruction buffer
    input  logic                      ib_stall_i,
    output logic [`FETCH_WIDTH-1:0]   ib_valid_o,
    output logic [`FETCH_WIDTH-1:0]   ib_last_o,
    output addr_t [`FETCH_WIDTH-1:0]  ib_pc_o,
    output instr_t [`FETCH_WIDTH-1:0] ib_instr_o
);

    // Global line holding the start PC
    function automatic line_idx_t line_of(input addr_t pc);
        return pc[`BANK_DEPTH_LOG2+4:4];
    endfunction

    // Block runs past the last word of its first line
    function automatic logic crosses_line(input addr_t pc, input fetch_len_t len);
        logic [3:0] end_word;
        end_word = {2'b00, pc[3:2]} + {1'b0, len};
        return end_word > 4'd4;
    endfunction

    flush_state_e flush_state;
    flush_state_e flush_state_nxt;

    // P1 block
    logic       p1_valid;
    addr_t      p1_pc;
    fetch_len_t p1_len;
    line_idx_t  p1_first;
    logic       p1_cross;
    logic       p1_lines_ok;
    logic       p1_retire;
    logic       load_p1;

    // Request side
    logic       req_active;
    addr_t      req_pc;
    fetch_len_t req_len;
    line_idx_t  req_first;
    line_idx_t  req_second;
    logic       req_cross;

    // Returned lines in block order
    line_t                        first_data;
    line_t                        second_data;
    instr_t [2*`FETCH_WIDTH-1:0]  line_words;

    logic [`FETCH_WIDTH-1:0]   lane_valid;
    logic [`FETCH_WIDTH-1:0]   lane_last;
    addr_t [`FETCH_WIDTH-1:0]  lane_pc;
    instr_t [`FETCH_WIDTH-1:0] lane_instr;

    // Drain lasts one cycle since bank latency is fixed
    always_comb begin
        flush_state_nxt = flush_state;
        case (flush_state)
            FLUSH_IDLE: begin
                if (flush_i) begin
                    flush_state_nxt = FLUSH_DRAIN;
                end
            end
            FLUSH_DRAIN: begin
                if (!flush_i) begin
                    flush_state_nxt = FLUSH_IDLE;
                end
            end
            default: flush_state_nxt = FLUSH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_state <= FLUSH_IDLE;
        end else begin
            flush_state <= flush_state_nxt;
        end
    end

    // P1 retire needs every line it asked for
    assign p1_first    = line_of(p1_pc);
    assign p1_cross    = crosses_line(p1_pc, p1_len);
    assign p1_lines_ok = ((p1_first[0] && !p1_cross) || bank0.rvalid)
                      && ((!p1_first[0] && !p1_cross) || bank1.rvalid);
    assign p1_retire   = p1_valid && p1_lines_ok && !ib_stall_i && !flush_i
                      && (flush_state == FLUSH_IDLE);

    // P0 loads when the slot is free or freeing up
    assign load_p1      = ftq_valid_i && (!p1_valid || p1_retire) && !flush_i;
    assign ftq_accept_o = load_p1;

    // New block reads now, a held block re-reads every cycle
    assign req_active = load_p1 || (p1_valid && !p1_retire);
    assign req_pc     = load_p1 ? ftq_pc_i : p1_pc;
    assign req_len    = load_p1 ? ftq_len_i : p1_len;
    assign req_first  = line_of(req_pc);
    assign req_second = req_first + line_idx_t'(1);
    assign req_cross  = crosses_line(req_pc, req_len);

    // Steer by parity of the first line
    assign bank0.rreq  = req_active && (!req_first[0] || req_cross);
    assign bank1.rreq  = req_active && (req_first[0] || req_cross);
    assign bank0.raddr = req_first[0] ? req_second : req_first;
    assign bank1.raddr = req_first[0] ? req_first : req_second;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1_valid <= 1'b0;
        end else if (flush_i) begin
            p1_valid <= 1'b0;
        end else if (load_p1) begin
            p1_valid <= 1'b1;
        end else if (p1_retire) begin
            p1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_p1) begin
            p1_pc  <= ftq_pc_i;
            p1_len <= ftq_len_i;
        end
    end

    // Put the first line in the low words
    assign first_data  = p1_first[0] ? bank1.rdata : bank0.rdata;
    assign second_data = p1_first[0] ? bank0.rdata : bank1.rdata;
    assign line_words  = {second_data, first_data};

    // Lane alignment
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_valid[i] = fetch_len_t'(i) < p1_len;
            lane_last[i]  = fetch_len_t'(i + 1) == p1_len;
            lane_pc[i]    = p1_pc + addr_t'(i << 2);
            lane_instr[i] = line_words[3'(p1_pc[3:2]) + 3'(i)];
        end
    end

    // P2 flags, flush clears and stall holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ib_valid_o <= '0;
            ib_last_o  <= '0;
        end else if (flush_i) begin
            ib_valid_o <= '0;
            ib_last_o  <= '0;
        end else if (!ib_stall_i) begin
            ib_valid_o <= p1_retire ? lane_valid : '0;
            ib_last_o  <= p1_retire ? lane_last : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (p1_retire) begin
            ib_pc_o    <= lane_pc;
            ib_instr_o <= lane_instr;
        end
    end

endmodule

// ==== hdl/icache_bank.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module icache_bank import fetch_pkg::*; #(
    parameter int unsigned BANK_ID = 0
) (
    input  logic       clk,
    input  logic       rst_n,

    // Line load port
    input  logic       mem_we_i,
    input  line_idx_t  mem_line_i,
    input  line_t      mem_wdata_i,

    // Read port toward the fetch unit
    fetch_bank_if.bank bank
);

    localparam int unsigned BANK_LINES = 1 << `BANK_DEPTH_LOG2;

    line_t mem [BANK_LINES];

    logic [`BANK_DEPTH_LOG2-1:0] wr_row;
    logic [`BANK_DEPTH_LOG2-1:0] rd_row;
    logic                        wr_hit;

    // Global index parity picks the bank, the rest is the row
    assign wr_hit = mem_we_i && (mem_line_i[0] == BANK_ID[0]);
    assign wr_row = mem_line_i[`BANK_DEPTH_LOG2:1];

    // Fetch unit only sends lines of this parity
    assign rd_row = bank.raddr[`BANK_DEPTH_LOG2:1];

    // Load port
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[wr_row] <= mem_wdata_i;
        end
    end

    // Response valid follows the request by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank.rvalid <= 1'b0;
        end else begin
            bank.rvalid <= bank.rreq;
        end
    end

    // Line data, only updated on a request
    always_ff @(posedge clk) begin
        if (bank.rreq) begin
            bank.rdata <= mem[rd_row];
        end
    end

endmodule

// ==== tests/fetch_frontend_tb.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_frontend_tb import fetch_pkg::*; ();

    localparam int NUM_LINES      = 1 << (`BANK_DEPTH_LOG2 + 1);
    localparam int NUM_WORDS      = NUM_LINES * 4;
    localparam int ACCEPT_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT  = 32;

    typedef logic [263:0] wide_t;

    // Accepted block as the instruction buffer should see it
    typedef struct packed {
        addr_t       pc;
        fetch_len_t  len;
        logic [31:0] cycle;
    } block_t;

    logic                      clk;
    logic                      rst_n;
    logic                      ftq_valid_i;
    addr_t                     ftq_pc_i;
    fetch_len_t                ftq_len_i;
    logic                      ftq_accept_o;
    logic                      mem_we_i;
    line_idx_t                 mem_line_i;
    line_t                     mem_wdata_i;
    logic                      ib_stall_i;
    logic [`FETCH_WIDTH-1:0]   ib_valid_o;
    logic [`FETCH_WIDTH-1:0]   ib_last_o;
    addr_t [`FETCH_WIDTH-1:0]  ib_pc_o;
    instr_t [`FETCH_WIDTH-1:0] ib_instr_o;
    logic                      flush_i;

    instr_t      model_mem [NUM_WORDS];
    block_t      exp_q [$];
    logic        accept_seen;
    logic        check_latency;
    logic        hold_valid;
    logic        prev_stall;
    logic        prev_flush;
    wide_t       prev_out;
    logic [31:0] cycle_count;

    int lane_errors;
    int accept_errors;
    int flow_errors;
    int blocks_checked;
    int cross_even;
    int cross_odd;
    int stall_holds;
    int flushed_blocks;

    fetch_frontend_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ftq_valid_i  (ftq_valid_i),
        .ftq_pc_i     (ftq_pc_i),
        .ftq_len_i    (ftq_len_i),
        .ftq_accept_o (ftq_accept_o),
        .mem_we_i     (mem_we_i),
        .mem_line_i   (mem_line_i),
        .mem_wdata_i  (mem_wdata_i),
        .ib_stall_i   (ib_stall_i),
        .ib_valid_o   (ib_valid_o),
        .ib_last_o    (ib_last_o),
        .ib_pc_o      (ib_pc_o),
        .ib_instr_o   (ib_instr_o),
        .flush_i      (flush_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // No accept without an offered block
    accept_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ftq_accept_o |-> ftq_valid_i)
    else begin
        accept_errors++;
        $display("ERROR accept_without_valid: expected 0, actual 1");
    end

    task automatic report_mismatch(input string test, input wide_t expected,
                                   input wide_t actual);
        lane_errors++;
        $display("ERROR %s: expected %0h, actual %0h at %0t", test, expected, actual, $time);
    endtask

    // Lane i holds pc+4i and the model word there
    task automatic compare_lanes(input block_t blk);
        int         lane_cnt;
        logic [1:0] lane;
        logic       exp_valid;
        logic       exp_last;
        addr_t      exp_pc;
        instr_t     exp_word;
        lane_cnt = int'(blk.len);
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane      = 2'(i);
            exp_valid = i < lane_cnt;
            exp_last  = (i + 1) == lane_cnt;
            exp_pc    = blk.pc + addr_t'(4 * i);
            exp_word  = model_mem[exp_pc[10:2]];
            assert (ib_valid_o[lane] === exp_valid)
                else report_mismatch("lane_valid", wide_t'(exp_valid), wide_t'(ib_valid_o[lane]));
            assert (ib_last_o[lane] === exp_last)
                else report_mismatch("lane_last", wide_t'(exp_last), wide_t'(ib_last_o[lane]));
            if (exp_valid) begin
                assert (ib_pc_o[lane] === exp_pc)
                    else report_mismatch("lane_pc", wide_t'(exp_pc), wide_t'(ib_pc_o[lane]));
                assert (ib_instr_o[lane] === exp_word)
                    else report_mismatch("lane_instr", wide_t'(exp_word),
                                         wide_t'(ib_instr_o[lane]));
            end
        end
    endtask

    // Scoreboard pops a block on each non-stalled edge with valid lanes
    always @(posedge clk) begin
        block_t blk;
        wide_t  out_now;
        accept_seen = ftq_accept_o;
        if (!rst_n) begin
            exp_q.delete();
            hold_valid = 1'b0;
        end else begin
            out_now = {ib_valid_o, ib_last_o, ib_pc_o, ib_instr_o};
            if (hold_valid && prev_stall && !prev_flush) begin
                if (ib_valid_o != '0) begin
                    stall_holds++;
                end
                assert (out_now === prev_out)
                    else report_mismatch("stall_hold", prev_out, out_now);
            end
            if (flush_i) begin
                if (ftq_accept_o) begin
                    lane_errors++;
                    $display("ERROR flush_accept: block accepted during a flush");
                end
                flushed_blocks += exp_q.size();
                exp_q.delete();
            end else begin
                if (ib_valid_o != '0 && !ib_stall_i) begin
                    if (exp_q.size() == 0) begin
                        lane_errors++;
                        $display("ERROR block_order: lanes %h shown with no block pending",
                                 ib_valid_o);
                    end else begin
                        blk = exp_q.pop_front();
                        compare_lanes(blk);
                        blocks_checked++;
                        if ({2'b00, blk.pc[3:2]} + {1'b0, blk.len} > 4'd4) begin
                            if (blk.pc[4]) begin
                                cross_odd++;
                            end else begin
                                cross_even++;
                            end
                        end
                        if (check_latency) begin
                            assert (cycle_count - blk.cycle == 32'd2)
                                else report_mismatch("latency", wide_t'(2),
                                                     wide_t'(cycle_count - blk.cycle));
                        end
                    end
                end
                if (ftq_accept_o) begin
                    blk.pc    = ftq_pc_i;
                    blk.len   = ftq_len_i;
                    blk.cycle = cycle_count;
                    exp_q.push_back(blk);
                end
            end
            prev_out   = out_now;
            prev_stall = ib_stall_i;
            prev_flush = flush_i;
            hold_valid = 1'b1;
        end
        cycle_count++;
    end

    task automatic verify_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            assert (ib_valid_o == '0) else begin
                flow_errors++;
                $display("ERROR reset_valid: expected 0, actual %0h", ib_valid_o);
            end
            assert (!ftq_accept_o) else begin
                flow_errors++;
                $display("ERROR reset_accept: expected 0, actual %0b", ftq_accept_o);
            end
        end
    endtask

    // Fill every line through the write port and mirror it
    task automatic load_memory();
        line_t  line_data;
        instr_t word;
        for (int l = 0; l < NUM_LINES; l++) begin
            @(negedge clk);
            for (int k = 0; k < 4; k++) begin
                word = $urandom;
                line_data[k*32 +: 32] = word;
                model_mem[l * 4 + k]  = word;
            end
            mem_we_i    = 1'b1;
            mem_line_i  = line_idx_t'(l);
            mem_wdata_i = line_data;
        end
        @(negedge clk);
        mem_we_i = 1'b0;
    endtask

    // Offered block stays up until it is accepted
    task automatic drive_blocks(input int n_blocks, input int offer_pct,
                                input int stall_pct, input int flush_pct);
        int          sent;
        int          waited;
        int unsigned len;
        int unsigned word;
        sent   = 0;
        waited = 0;
        while (sent < n_blocks && waited < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            if (ftq_valid_i && accept_seen) begin
                sent++;
                waited      = 0;
                ftq_valid_i = 1'b0;
            end else if (ftq_valid_i) begin
                waited++;
            end
            if (!ftq_valid_i && sent < n_blocks && int'($urandom % 100) < offer_pct) begin
                len         = 1 + $urandom % 4;
                word        = $urandom % (NUM_WORDS + 1 - len);
                ftq_valid_i = 1'b1;
                ftq_pc_i    = addr_t'(word << 2);
                ftq_len_i   = fetch_len_t'(len);
            end
            ib_stall_i = int'($urandom % 100) < stall_pct;
            flush_i    = int'($urandom % 100) < flush_pct;
        end
        if (ftq_valid_i && waited >= ACCEPT_TIMEOUT) begin
            flow_errors++;
            $display("Timeout: block at pc %h not accepted within %0d cycles",
                     ftq_pc_i, ACCEPT_TIMEOUT);
        end
        @(negedge clk);
        ftq_valid_i = 1'b0;
        ib_stall_i  = 1'b0;
        flush_i     = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || ib_valid_o != '0) && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || ib_valid_o != '0) begin
            flow_errors++;
            $display("Timeout: %0d accepted blocks never reached the outputs", exp_q.size());
        end
    endtask

    initial begin
        void'($urandom(69));
        rst_n         = 1'b0;
        ftq_valid_i   = 1'b0;
        ftq_pc_i      = '0;
        ftq_len_i     = '0;
        mem_we_i      = 1'b0;
        mem_line_i    = '0;
        mem_wdata_i   = '0;
        ib_stall_i    = 1'b0;
        flush_i       = 1'b0;
        check_latency = 1'b0;
        cycle_count   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        verify_idle(4);
        load_memory();

        // Back-to-back stream with a fixed two-cycle latency
        check_latency = 1'b1;
        drive_blocks(40, 100, 0, 0);
        drain_outputs();
        check_latency = 1'b0;

        // Mixed stall and flush traffic
        drive_blocks(300, 70, 25, 3);
        drive_blocks(60, 100, 50, 0);
        drain_outputs();

        $display("Blocks %0d, crossing even %0d odd %0d, stall holds %0d, flushed %0d",
                 blocks_checked, cross_even, cross_odd, stall_holds, flushed_blocks);
        if (cross_even == 0 || cross_odd == 0 || stall_holds == 0 || flushed_blocks == 0) begin
            flow_errors++;
            $display("Stimulus missed a case: line crossing, stall hold or flush drop");
        end
        $display("Errors: lane %0d, accept %0d, flow %0d",
                 lane_errors, accept_errors, flow_errors);
        if (lane_errors + accept_errors + flow_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
